// File: apb_timer_sys.f
source/apb_map_pkg.sv
source/timer_pkg.sv
source/apb_decoder.sv
source/timer_regs.sv
source/timer_counter.sv
source/apb_timer_sys.sv
dv/apb_timer_sys_checker.sv
dv/apb_timer_sys_tb.sv

// File: Makefile
# Verilator simulation of the APB timer subsystem

VERILATOR ?= verilator
TOP       ?= apb_timer_sys_tb
FILELIST  ?= apb_timer_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	   echo "Simulation passed"; \
	else \
	   echo "Simulation failed, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/apb_timer_sys_tb.sv
/*
 * APB timer subsystem testbench
 * Directed APB tests of reset values, readback, errors, counting and interrupt
 */
`timescale 1ns/100ps

module apb_timer_sys_tb import apb_map_pkg::*, timer_pkg::*; ();

   // About 500 cycles of tests at 10 ns, with ample margin
   localparam int unsigned TIMEOUT_NS = 20000;
   localparam logic [31:0] CTRL_MASK  = (32'd1 << CTRL_EN_BIT) |
                                        (((32'd1 << PRESCALE_W) - 32'd1) << CTRL_PRE_LSB);
   localparam logic [31:0] CTRL_ON    = 32'd1 << CTRL_EN_BIT;

   logic                  clk;
   logic                  rst_n_i;
   logic                  psel_i;
   logic                  penable_i;
   logic                  pwrite_i;
   logic [APB_ADDR_W-1:0] paddr_i;
   logic [APB_DATA_W-1:0] pwdata_i;
   logic [APB_DATA_W-1:0] prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic                  irq_o;

   logic [31:0] rng_state = 32'hcc64;
   logic        irq_seen  = 1'b0;
   int unsigned cyc       = 0;

   apb_timer_sys dut_i (.*);

   always #5 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;
   always @(negedge clk) if (irq_o) irq_seen = 1'b1;   // Sampled away from the edge

   //************************************************************
   // Helpers
   //************************************************************
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act)
         report_failure($sformatf("mismatch %s expected %h actual %h", test, exp, act));
   endtask

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [APB_ADDR_W-1:0] addr_of(input logic [SLOT_W-1:0] slot,
                                                     input logic [3:0] offset);
      logic [APB_ADDR_W-1:0] a;
      a = '0;
      a[SLOT_LSB +: SLOT_W] = slot;
      a[3:0] = offset;
      return a;
   endfunction

   // Setup cycle, then access cycle sampled at the falling edge
   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      @(posedge clk);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(posedge clk);
      #1 penable_i = 1'b1;
      @(negedge clk);
      if (pready_o !== 1'b1) report_failure("pready_o was not high in a write access cycle");
      err = pslverr_o;
      @(posedge clk);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(posedge clk);
      #1 penable_i = 1'b1;
      @(negedge clk);
      if (pready_o !== 1'b1) report_failure("pready_o was not high in a read access cycle");
      data = prdata_o;
      err  = pslverr_o;
      @(posedge clk);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   //************************************************************
   // Directed tests
   //************************************************************
   task automatic reset_values();
      logic [31:0] rd;
      logic        err;
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
      check_value("reset_values count", 32'd0, rd);
      check_value("reset_values count err", 32'd0, 32'(err));
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), rd, err);
      check_value("reset_values ctrl", 32'd0, rd);
      check_value("reset_values ctrl err", 32'd0, 32'(err));
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), rd, err);
      check_value("reset_values cmp", CMP_RESET, rd);
      check_value("reset_values cmp err", 32'd0, 32'(err));
   endtask

   task automatic readback();
      logic [31:0] v;
      logic [31:0] rd;
      logic        err;
      repeat (4) begin
         v = next_rand();
         apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), v, err);
         check_value("readback ctrl write err", 32'd0, 32'(err));
         apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), rd, err);
         check_value("readback ctrl", v & CTRL_MASK, rd);
         v = next_rand();
         apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), v, err);
         check_value("readback cmp write err", 32'd0, 32'(err));
         apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), rd, err);
         check_value("readback cmp", v, rd);
         check_value("readback cmp read err", 32'd0, 32'(err));
      end
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), 32'd0, err);
   endtask

   task automatic error_responses();
      logic [APB_ADDR_W-1:0] bad [$];
      logic [31:0]           rd;
      logic                  err;
      // Known state with the counter stopped
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), 32'd0, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), 32'h55, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), 32'h1234, err);
      for (int s = 0; s < 8; s++) begin
         if (s != TIMER_SLOT) bad.push_back(addr_of(SLOT_W'(s), REG_CTRL));
      end
      bad.push_back(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL) | 20'h10000);   // Upper bits set
      bad.push_back(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP) | 20'h80000);
      bad.push_back(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT) | 20'h40000);
      foreach (bad[i]) begin
         apb_write(bad[i], next_rand(), err);
         check_value("error_responses write err", 32'd1, 32'(err));
         apb_read(bad[i], rd, err);
         check_value("error_responses read err", 32'd1, 32'(err));
         check_value("error_responses read data", 32'd0, rd);
      end
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), 4'hC), 32'hFFFF_FFFF, err);
      check_value("error_responses offset write err", 32'd1, 32'(err));
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), 4'hC), rd, err);
      check_value("error_responses offset read err", 32'd1, 32'(err));
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
      check_value("error_responses count kept", 32'h55, rd);
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), rd, err);
      check_value("error_responses ctrl kept", 32'd0, rd);
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), rd, err);
      check_value("error_responses cmp kept", 32'h1234, rd);
   endtask

   task automatic count_and_hold();
      logic [31:0] rd;
      logic [31:0] first;
      logic        err;
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), 32'hFFFF_0000, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), 32'd100, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), CTRL_ON, err);
      repeat (40) @(posedge clk);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), 32'd0, err);
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
      check_value("count_and_hold advanced", 32'd1, 32'(rd > 32'd100));
      repeat (20) @(posedge clk);
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), first, err);
      repeat (10) @(posedge clk);
      apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
      check_value("count_and_hold held", first, rd);
   endtask

   task automatic wrap_and_irq();
      logic [31:0] rd;
      logic        err;
      int unsigned start;
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), 32'd0, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CMP), 32'd5, err);
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), 32'd0, err);
      irq_seen = 1'b0;
      start    = cyc;
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), CTRL_ON | (32'd2 << CTRL_PRE_LSB), err);
      while (!irq_seen && (cyc - start) < 100) begin
         apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
         check_value("wrap_and_irq count bound", 32'd1, 32'(rd <= 32'd5));
      end
      if (!irq_seen) report_failure("irq_o did not go high within 100 cycles");
      repeat (8) begin   // Keep watching past the wrap
         apb_read(addr_of(SLOT_W'(TIMER_SLOT), REG_COUNT), rd, err);
         check_value("wrap_and_irq count after wrap", 32'd1, 32'(rd <= 32'd5));
      end
      apb_write(addr_of(SLOT_W'(TIMER_SLOT), REG_CTRL), 32'd0, err);
   endtask

   //************************************************************
   // Sequence, assertion monitor and watchdog
   //************************************************************
   always @(negedge clk) begin
      if (dut_i.u_checker.fail_count != 0)
         report_failure("a protocol assertion in the bound checker failed");
   end

   initial begin
      #(TIMEOUT_NS);
      report_failure("watchdog expired before the tests finished");
   end

   initial begin
      clk       = 1'b0;
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      repeat (5) @(posedge clk);
      #1 rst_n_i = 1'b1;
      reset_values();
      readback();
      error_responses();
      count_and_hold();
      wrap_and_irq();
      repeat (2) @(posedge clk);
      if (dut_i.u_checker.fail_count == 0) begin
         $display("No errors");
         $finish;
      end else begin
         report_failure("protocol assertions failed during the run");
      end
   end

endmodule

// File: dv/apb_timer_sys_checker.sv
/*
 * APB timer protocol checker
 * Concurrent assertions on the APB response and the interrupt pulse
 */
`timescale 1ns/100ps

module apb_timer_sys_checker (
   input logic clk,
   input logic rst_n_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_i,
   input logic pslverr_i,
   input logic irq_i
);

   int unsigned fail_count = 0;   // Watched by the testbench

   //************************************************************
   // APB response
   //************************************************************
   a_ready_in_access : assert property (@(posedge clk) disable iff (!rst_n_i)
      pready_i |-> (psel_i && penable_i))
      else begin
         $error("pready_o high outside an access cycle");
         fail_count++;
      end

   a_err_with_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
      pslverr_i |-> pready_i)
      else begin
         $error("pslverr_o high without pready_o");
         fail_count++;
      end

   //************************************************************
   // Interrupt
   //************************************************************
   a_irq_single : assert property (@(posedge clk) disable iff (!rst_n_i)
      irq_i |=> !irq_i)
      else begin
         $error("irq_o high for two cycles in a row");
         fail_count++;
      end

   // Checked during reset as well
   a_irq_reset : assert property (@(posedge clk) !rst_n_i |-> !irq_i)
      else begin
         $error("irq_o high while in reset");
         fail_count++;
      end

endmodule

bind apb_timer_sys apb_timer_sys_checker u_checker (
   .clk       (clk),
   .rst_n_i   (rst_n_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_i  (pready_o),
   .pslverr_i (pslverr_o),
   .irq_i     (irq_o)
);

// File: source/apb_timer_sys.sv
/*
 * APB timer subsystem
 * Zero-wait-state APB slave with the slot decoder, timer registers and counter
 */
`timescale 1ns/100ps

module apb_timer_sys import apb_map_pkg::*, timer_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n_i,

   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic [APB_DATA_W-1:0] pwdata_i,
   output logic [APB_DATA_W-1:0] prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,

   output logic                  irq_o
);

   // Decoder to registers
   logic                    tmr_sel;
   logic                    tmr_enable;
   logic                    tmr_write;
   logic [REG_OFFSET_W-1:0] tmr_offset;
   logic [APB_DATA_W-1:0]   tmr_wdata;
   logic [APB_DATA_W-1:0]   tmr_prdata;
   logic                    tmr_slverr;

   // Registers to counter
   logic                    cnt_en;
   logic [PRESCALE_W-1:0]   cnt_prescale;
   logic [COUNT_W-1:0]      cnt_cmp;
   logic                    cnt_ld;
   logic [COUNT_W-1:0]      cnt_ld_val;
   logic [COUNT_W-1:0]      cnt_value;

   //************************************************************
   // Address decode stage
   //************************************************************
   apb_decoder u_decoder (
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .tmr_sel_o    (tmr_sel),
      .tmr_enable_o (tmr_enable),
      .tmr_write_o  (tmr_write),
      .tmr_offset_o (tmr_offset),
      .tmr_wdata_o  (tmr_wdata),
      .tmr_prdata_i (tmr_prdata),
      .tmr_slverr_i (tmr_slverr)
   );

   //************************************************************
   // Register access stage
   //************************************************************
   timer_regs u_regs (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .sel_i          (tmr_sel),
      .enable_i       (tmr_enable),
      .write_i        (tmr_write),
      .offset_i       (tmr_offset),
      .wdata_i        (tmr_wdata),
      .rdata_o        (tmr_prdata),
      .slverr_o       (tmr_slverr),
      .count_i        (cnt_value),
      .en_o           (cnt_en),
      .prescale_o     (cnt_prescale),
      .cmp_o          (cnt_cmp),
      .count_ld_o     (cnt_ld),
      .count_ld_val_o (cnt_ld_val)
   );

   //************************************************************
   // Counting stage
   //************************************************************
   timer_counter u_counter (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .en_i           (cnt_en),
      .prescale_i     (cnt_prescale),
      .cmp_i          (cnt_cmp),
      .count_ld_i     (cnt_ld),
      .count_ld_val_i (cnt_ld_val),
      .count_o        (cnt_value),
      .irq_o          (irq_o)
   );

endmodule

// File: source/timer_counter.sv
/*
 * Timer counter
 * Prescaler, 32-bit count with compare wrap, and the interrupt pulse
 */
`timescale 1ns/100ps

module timer_counter import timer_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  en_i,
   input  logic [PRESCALE_W-1:0] prescale_i,
   input  logic [COUNT_W-1:0]    cmp_i,
   input  logic                  count_ld_i,
   input  logic [COUNT_W-1:0]    count_ld_val_i,
   output logic [COUNT_W-1:0]    count_o,
   output logic                  irq_o
);

   logic [PRESCALE_W-1:0] pre_cnt;
   logic [COUNT_W-1:0]    count_q;
   logic                  irq_q;
   logic                  tick;
   logic                  match;

   assign tick  = en_i && (pre_cnt == prescale_i);   // Once every prescale+1 clocks
   assign match = (count_q == cmp_i);

   //************************************************************
   // Prescaler and count
   //************************************************************
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pre_cnt <= '0;
         count_q <= '0;
         irq_q   <= 1'b0;
      end else begin
         irq_q <= 1'b0;
         if (count_ld_i) begin
            count_q <= count_ld_val_i;
            pre_cnt <= '0;                   // Restart the phase
         end else if (!en_i) begin
            pre_cnt <= '0;                   // Count holds
         end else if (tick) begin
            pre_cnt <= '0;
            if (match) begin
               count_q <= '0;
               irq_q   <= 1'b1;              // Pulse in the cycle after the wrap
            end else begin
               count_q <= count_q + 1'b1;
            end
         end else begin
            pre_cnt <= pre_cnt + 1'b1;
         end
      end
   end

   assign count_o = count_q;
   assign irq_o   = irq_q;

endmodule

// File: source/timer_regs.sv
/*
 * Timer register file
 * APB read mux, write strobes and offset check for count, control and compare
 */
`timescale 1ns/100ps

module timer_regs import apb_map_pkg::*, timer_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n_i,

   // Slave side of the decoder
   input  logic                    sel_i,
   input  logic                    enable_i,
   input  logic                    write_i,
   input  logic [REG_OFFSET_W-1:0] offset_i,
   input  logic [APB_DATA_W-1:0]   wdata_i,
   output logic [APB_DATA_W-1:0]   rdata_o,
   output logic                    slverr_o,

   // Counter controls
   input  logic [COUNT_W-1:0]      count_i,
   output logic                    en_o,
   output logic [PRESCALE_W-1:0]   prescale_o,
   output logic [COUNT_W-1:0]      cmp_o,
   output logic                    count_ld_o,
   output logic [COUNT_W-1:0]      count_ld_val_o
);

   logic                  access;
   logic                  wr;
   logic                  hit_count;
   logic                  hit_ctrl;
   logic                  hit_cmp;
   logic                  reg_hit;

   logic                  en_q;
   logic [PRESCALE_W-1:0] pre_q;
   logic [COUNT_W-1:0]    cmp_q;
   logic [APB_DATA_W-1:0] ctrl_rd;

   //************************************************************
   // Offset decode
   //************************************************************
   assign access    = sel_i & enable_i;
   assign hit_count = (offset_i == REG_COUNT);
   assign hit_ctrl  = (offset_i == REG_CTRL);
   assign hit_cmp   = (offset_i == REG_CMP);
   assign reg_hit   = hit_count | hit_ctrl | hit_cmp;

   assign wr        = access & write_i & reg_hit;   // Bad offsets drop the write
   assign slverr_o  = access & ~reg_hit;

   //************************************************************
   // Control and compare registers
   //************************************************************
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q  <= 1'b0;
         pre_q <= '0;
         cmp_q <= CMP_RESET;
      end else begin
         if (wr && hit_ctrl) begin
            en_q  <= wdata_i[CTRL_EN_BIT];
            pre_q <= wdata_i[CTRL_PRE_LSB +: PRESCALE_W];
         end
         if (wr && hit_cmp) begin
            cmp_q <= wdata_i;
         end
      end
   end

   assign en_o       = en_q;
   assign prescale_o = pre_q;
   assign cmp_o      = cmp_q;

   // The counter takes the load on the same edge as the access
   assign count_ld_o     = wr & hit_count;
   assign count_ld_val_o = wdata_i;

   //************************************************************
   // Read mux
   //************************************************************
   always_comb begin
      ctrl_rd                                = '0;   // Unused control bits read 0
      ctrl_rd[CTRL_EN_BIT]                   = en_q;
      ctrl_rd[CTRL_PRE_LSB +: PRESCALE_W]    = pre_q;
   end

   always_comb begin
      rdata_o = '0;
      if (hit_count) begin
         rdata_o = count_i;
      end else if (hit_ctrl) begin
         rdata_o = ctrl_rd;
      end else if (hit_cmp) begin
         rdata_o = cmp_q;
      end
   end

endmodule

// File: source/apb_decoder.sv
/*
 * APB slot decoder
 * Steers the access phase to the timer and answers unmapped slots with an error
 */
`timescale 1ns/100ps

module apb_decoder import apb_map_pkg::*; (
   // Upstream APB
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  logic [APB_ADDR_W-1:0]   paddr_i,
   input  logic [APB_DATA_W-1:0]   pwdata_i,
   output logic [APB_DATA_W-1:0]   prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,

   // Timer slot
   output logic                    tmr_sel_o,
   output logic                    tmr_enable_o,
   output logic                    tmr_write_o,
   output logic [REG_OFFSET_W-1:0] tmr_offset_o,
   output logic [APB_DATA_W-1:0]   tmr_wdata_o,
   input  logic [APB_DATA_W-1:0]   tmr_prdata_i,
   input  logic                    tmr_slverr_i
);

   logic [SLOT_W-1:0]                     slot;
   logic [APB_ADDR_W-SLOT_LSB-SLOT_W-1:0] upper;
   logic                                  tmr_hit;
   logic                                  access;

   assign slot    = paddr_i[SLOT_LSB +: SLOT_W];
   assign upper   = paddr_i[APB_ADDR_W-1:SLOT_LSB+SLOT_W];   // Must be zero for any hit

   assign tmr_hit = (slot == SLOT_W'(TIMER_SLOT)) && (upper == '0);
   assign access  = psel_i & penable_i;

   //************************************************************
   // Request side
   //************************************************************
   // Only a timer hit raises the select, so other slots never write
   assign tmr_sel_o    = psel_i & tmr_hit;
   assign tmr_enable_o = penable_i & tmr_hit;
   assign tmr_write_o  = pwrite_i;
   assign tmr_offset_o = paddr_i[REG_OFFSET_W-1:0];
   assign tmr_wdata_o  = pwdata_i;

   //************************************************************
   // Response side
   //************************************************************
   assign pready_o = access;   // Zero wait states

   always_comb begin
      prdata_o  = '0;
      pslverr_o = 1'b0;
      if (access) begin
         if (tmr_hit) begin
            prdata_o  = tmr_prdata_i;
            pslverr_o = tmr_slverr_i;
         end else begin
            pslverr_o = 1'b1;           // Unmapped slot
         end
      end
   end

endmodule

// File: source/timer_pkg.sv
/*
 * Timer package
 * Register offsets, control field layout and reset values of the timer
 */
package timer_pkg;

   //************************************************************
   // Register offsets
   //************************************************************
   localparam logic [3:0] REG_COUNT = 4'h0;   // Current count, a write loads it
   localparam logic [3:0] REG_CTRL  = 4'h4;   // Enable and prescaler
   localparam logic [3:0] REG_CMP   = 4'h8;   // Wrap value

   //************************************************************
   // Control register fields
   //************************************************************
   localparam int unsigned CTRL_EN_BIT  = 0;
   localparam int unsigned CTRL_PRE_LSB = 3;
   localparam int unsigned PRESCALE_W   = 3;   // Tick every prescale+1 clocks

   // Width of the count and compare registers
   localparam int unsigned COUNT_W = 32;

   //************************************************************
   // Reset values
   //************************************************************
   // Compare starts at all ones so a fresh timer runs the full range
   localparam logic [COUNT_W-1:0] CMP_RESET = 32'hFFFF_FFFF;

endpackage

// File: source/apb_map_pkg.sv
/*
 * APB map package
 * Bus widths and the peripheral slot layout behind the APB interconnect
 */
package apb_map_pkg;

   //************************************************************
   // APB bus widths
   //************************************************************
   localparam int unsigned APB_ADDR_W   = 20;   // Matches the bridge's APB address
   localparam int unsigned APB_DATA_W   = 32;

   //************************************************************
   // Slot decode
   //************************************************************
   // Each slot covers 0x2000 of address space
   //   slot 1  0x02000  timer
   //   slot 2  0x04000  pwm (not present)
   //   slot 3  0x06000  uart (not present)
   //   slot 4  0x08000  gpio (not present)
   //   slot 5  0x0A000  spi (not present)
   //   slot 7  0x0E000  i2c (not present)
   localparam int unsigned SLOT_LSB     = 13;
   localparam int unsigned SLOT_W       = 3;
   localparam int unsigned TIMER_SLOT   = 1;

   // Low address bits handed to a peripheral
   localparam int unsigned REG_OFFSET_W = 4;

endpackage
